/* Makefile */
TOP := tb_serv_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f *.sv serv_defines.svh
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module serv_top

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+.
serv_isa_pkg.sv
serv_ctrl_pkg.sv
serv_state.sv
serv_decode.sv
serv_immdec.sv
serv_alu.sv
serv_rf.sv
serv_mem_if.sv
serv_top.sv
tb_serv_top.sv

/* serv_alu.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_alu (
   input  logic                          clk,
   input  logic                          i_exec_en,
   input  logic [$clog2(`SERV_XLEN)-1:0] i_cnt,
   input  serv_ctrl_pkg::ctrl_t          i_ctrl,
   input  logic                          i_rs1_bit,
   input  logic                          i_rs2_bit,
   input  logic                          i_imm_bit,
   output logic                          o_rd_bit
);
   import serv_ctrl_pkg::*;

   logic sub;
   logic op_b;
   logic b_add;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic carry_out;

   assign sub   = (i_ctrl.alu_op == ALU_SUB);
   assign op_b  = i_ctrl.use_imm ? i_imm_bit : i_rs2_bit;
   assign b_add = op_b ^ sub;

   // Subtract as a + ~b + 1
   assign carry_in  = (i_cnt == '0) ? sub : carry_q;
   assign sum       = i_rs1_bit ^ b_add ^ carry_in;
   assign carry_out = (i_rs1_bit & b_add) | (carry_in & (i_rs1_bit ^ b_add));

   always_ff @(posedge clk) begin
      if (i_exec_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         ALU_PASS_B: o_rd_bit = op_b;
         default:    o_rd_bit = sum;
      endcase
   end

endmodule

/* serv_ctrl_pkg.sv */
package serv_ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_XOR    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_AND    = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_t;

   // Decoded instruction, valid from the cycle after fetch ack
   typedef struct packed {
      alu_op_t    alu_op;
      logic       use_imm;
      logic       rd_wen;
      logic       is_store;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
   } ctrl_t;

   typedef enum logic [1:0] {
      ST_FETCH = 2'd0,
      ST_EXEC  = 2'd1,
      ST_STORE = 2'd2
   } seq_state_t;

endpackage

/* serv_decode.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_decode (
   input  logic                  clk,
   input  logic                  i_ibus_ack,
   input  logic [`SERV_XLEN-1:0] i_ibus_rdt,
   output serv_ctrl_pkg::ctrl_t  o_ctrl
);
   import serv_isa_pkg::*;
   import serv_ctrl_pkg::*;

   insn_u   insn;
   alu_op_t f3_op;
   logic    f3_ok;
   logic    f7_ok;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         insn <= i_ibus_rdt;
      end
   end

   // funct3 decode shared by register and immediate forms
   always_comb begin
      f3_op = ALU_ADD;
      f3_ok = 1'b1;
      case (insn.r.funct3)
         F3_ADD:  f3_op = ALU_ADD;
         F3_XOR:  f3_op = ALU_XOR;
         F3_OR:   f3_op = ALU_OR;
         F3_AND:  f3_op = ALU_AND;
         default: f3_ok = 1'b0;
      endcase
   end

   // Only bit 5 may be set, anything else is M extension or reserved
   assign f7_ok = ((insn.r.funct7 & 7'b1011111) == 7'd0);

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = ALU_ADD;
      o_ctrl.rd     = insn.r.rd;
      o_ctrl.rs1    = insn.r.rs1;
      o_ctrl.rs2    = insn.r.rs2;
      case (insn.r.opcode)
         OPC_OP_IMM: begin
            o_ctrl.alu_op  = f3_op;
            o_ctrl.use_imm = 1'b1;
            o_ctrl.rd_wen  = f3_ok;
         end
         OPC_OP: begin
            // SUB only exists for the add funct3
            if ((insn.r.funct3 == F3_ADD) && insn.r.funct7[5]) begin
               o_ctrl.alu_op = ALU_SUB;
            end else begin
               o_ctrl.alu_op = f3_op;
            end
            o_ctrl.rd_wen = f3_ok & f7_ok & ((insn.r.funct3 == F3_ADD) | ~insn.r.funct7[5]);
         end
         OPC_LUI: begin
            o_ctrl.alu_op  = ALU_PASS_B;
            o_ctrl.use_imm = 1'b1;
            o_ctrl.rd_wen  = 1'b1;
         end
         OPC_STORE: begin
            // Address is rs1 plus the S immediate
            o_ctrl.use_imm  = 1'b1;
            o_ctrl.is_store = (insn.r.funct3 == F3_SW);
         end
         default: ;
      endcase
   end

endmodule

/* serv_defines.svh */
`ifndef SERV_DEFINES_SVH
`define SERV_DEFINES_SVH

// Datapath width, also sets the bit counter width
`define SERV_XLEN 32

// Architectural integer registers
`define SERV_NREGS 32

// First fetch address out of reset
`define SERV_RESET_PC 32'h0000_0000

`endif

/* serv_immdec.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_immdec (
   input  logic                  clk,
   input  logic                  i_ibus_ack,
   input  logic [`SERV_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_exec_en,
   output logic                  o_imm_bit
);
   import serv_isa_pkg::*;

   insn_u                 word;
   logic [`SERV_XLEN-1:0] imm_n;
   logic [`SERV_XLEN-1:0] imm_q;

   assign word = i_ibus_rdt;

   always_comb begin
      case (word.r.opcode)
         OPC_OP_IMM: imm_n = {{(`SERV_XLEN-12){word.i.imm12[11]}}, word.i.imm12};
         OPC_STORE:  imm_n = {{(`SERV_XLEN-12){word.r.funct7[6]}}, word.r.funct7, word.r.rd};
         OPC_LUI:    imm_n = {word.r.funct7, word.r.rs2, word.r.rs1, word.r.funct3, 12'd0};
         default:    imm_n = '0;
      endcase
   end

   // LSB first, top bit replicated so I and S stay sign extended
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= imm_n;
      end else if (i_exec_en) begin
         imm_q <= {imm_q[`SERV_XLEN-1], imm_q[`SERV_XLEN-1:1]};
      end
   end

   assign o_imm_bit = imm_q[0];

endmodule

/* serv_isa_pkg.sv */
package serv_isa_pkg;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_STORE  = 7'b0100011
   } opcode_t;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_SW  = 3'b010;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_t    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_t     opcode;
   } i_fmt_t;

   // S and U immediates are pieced together from the R view
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } insn_u;

endpackage

/* serv_mem_if.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_mem_if (
   input  logic                      clk,
   input  logic                      i_exec_en,
   input  logic                      i_rd_bit,
   input  logic                      i_rs2_bit,
   output logic [`SERV_XLEN-1:0]     o_dbus_adr,
   output logic [`SERV_XLEN-1:0]     o_dbus_dat,
   output logic [`SERV_XLEN/8-1:0]   o_dbus_sel,
   output logic                      o_dbus_we
);

   // Address comes from the ALU sum, data straight from rs2
   always_ff @(posedge clk) begin
      if (i_exec_en) begin
         o_dbus_adr <= {i_rd_bit, o_dbus_adr[`SERV_XLEN-1:1]};
         o_dbus_dat <= {i_rs2_bit, o_dbus_dat[`SERV_XLEN-1:1]};
      end
   end

   // Word stores only
   assign o_dbus_sel = '1;
   assign o_dbus_we  = 1'b1;

endmodule

/* serv_rf.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_rf (
   input  logic                          clk,
   input  logic                          i_exec_en,
   input  logic [$clog2(`SERV_XLEN)-1:0] i_cnt,
   input  serv_ctrl_pkg::ctrl_t          i_ctrl,
   input  logic                          i_rd_bit,
   output logic                          o_rs1_bit,
   output logic                          o_rs2_bit
);

   logic [`SERV_XLEN-1:0] regs [`SERV_NREGS];
   logic                  wen;

   // x0 is never written, its storage is masked on read
   assign o_rs1_bit = (i_ctrl.rs1 != '0) & regs[i_ctrl.rs1][i_cnt];
   assign o_rs2_bit = (i_ctrl.rs2 != '0) & regs[i_ctrl.rs2][i_cnt];

   assign wen = i_exec_en & i_ctrl.rd_wen & (i_ctrl.rd != '0);

   // Bit cnt of rd is overwritten after it was read in the same cycle
   always_ff @(posedge clk) begin
      if (wen) begin
         regs[i_ctrl.rd][i_cnt] <= i_rd_bit;
      end
   end

endmodule

/* serv_state.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_state (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_ibus_ack,
   input  logic                          i_dbus_ack,
   input  serv_ctrl_pkg::ctrl_t          i_ctrl,
   output logic                          o_ibus_cyc,
   output logic [`SERV_XLEN-1:0]         o_ibus_adr,
   output logic                          o_dbus_cyc,
   output logic                          o_exec_en,
   output logic [$clog2(`SERV_XLEN)-1:0] o_cnt,
   output logic                          o_last
);
   import serv_ctrl_pkg::*;

   localparam int CW = $clog2(`SERV_XLEN);
   localparam logic [CW-1:0] CNT_LAST = CW'(`SERV_XLEN - 1);

   seq_state_t state;
   seq_state_t state_n;
   logic       fetch_done;
   logic       store_done;

   assign fetch_done = o_ibus_cyc & i_ibus_ack;
   assign store_done = o_dbus_cyc & i_dbus_ack;
   assign o_exec_en  = (state == ST_EXEC);
   assign o_last     = (o_cnt == CNT_LAST);

   always_comb begin
      state_n = state;
      case (state)
         ST_FETCH: if (fetch_done) state_n = ST_EXEC;
         ST_EXEC:  if (o_last) state_n = i_ctrl.is_store ? ST_STORE : ST_FETCH;
         ST_STORE: if (store_done) state_n = ST_FETCH;
         default:  state_n = ST_FETCH;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= ST_FETCH;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
         o_cnt      <= '0;
         o_ibus_adr <= `SERV_RESET_PC;
      end else begin
         state <= state_n;
         // Requests follow the next phase, so each drops in its ack cycle
         o_ibus_cyc <= (state_n == ST_FETCH);
         o_dbus_cyc <= (state_n == ST_STORE);
         // Wraps back to zero after the last bit
         if (o_exec_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         if ((o_exec_en & o_last & ~i_ctrl.is_store) | store_done) begin
            o_ibus_adr <= o_ibus_adr + `SERV_XLEN'(4);
         end
      end
   end

endmodule

/* serv_top.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module serv_top (
   input  logic                    clk,
   input  logic                    i_reset,
   output logic [`SERV_XLEN-1:0]   o_ibus_adr,
   output logic                    o_ibus_cyc,
   input  logic [`SERV_XLEN-1:0]   i_ibus_rdt,
   input  logic                    i_ibus_ack,
   output logic [`SERV_XLEN-1:0]   o_dbus_adr,
   output logic [`SERV_XLEN-1:0]   o_dbus_dat,
   output logic [`SERV_XLEN/8-1:0] o_dbus_sel,
   output logic                    o_dbus_we,
   output logic                    o_dbus_cyc,
   input  logic                    i_dbus_ack
);
   import serv_ctrl_pkg::*;

   ctrl_t                         ctrl;
   logic                          exec_en;
   logic [$clog2(`SERV_XLEN)-1:0] cnt;
   logic                          rs1_bit;
   logic                          rs2_bit;
   logic                          imm_bit;
   logic                          rd_bit;

   serv_state state_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_ctrl     (ctrl),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_dbus_cyc (o_dbus_cyc),
      .o_exec_en  (exec_en),
      .o_cnt      (cnt),
      .o_last     ()
   );

   serv_decode decode_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_ctrl     (ctrl)
   );

   serv_immdec immdec_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_exec_en  (exec_en),
      .o_imm_bit  (imm_bit)
   );

   serv_alu alu_i (
      .clk       (clk),
      .i_exec_en (exec_en),
      .i_cnt     (cnt),
      .i_ctrl    (ctrl),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit)
   );

   serv_rf rf_i (
      .clk       (clk),
      .i_exec_en (exec_en),
      .i_cnt     (cnt),
      .i_ctrl    (ctrl),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serv_mem_if mem_if_i (
      .clk        (clk),
      .i_exec_en  (exec_en),
      .i_rd_bit   (rd_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we)
   );

endmodule

/* tb_serv_top.sv */
`timescale 1ns/1ps
`include "serv_defines.svh"

module tb_serv_top;

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [2:0] F3_ADD     = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_SW      = 3'b010;
   // FENCE is not implemented by the core
   localparam logic [31:0] NOP_WORD  = 32'h0000_000f;

   localparam int PROG_WORDS        = 256;
   localparam int N_TESTS           = 6;
   // Upper bound on instructions over all tests
   localparam int TOTAL_INSNS       = 150;
   // Fetch plus exec plus a slow store
   localparam int WORST_INSN_CYCLES = 45;
   localparam int MAX_CYCLES        = TOTAL_INSNS * WORST_INSN_CYCLES * 6;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
   } store_t;

   logic                    clk;
   logic                    i_reset;
   logic [`SERV_XLEN-1:0]   o_ibus_adr;
   logic                    o_ibus_cyc;
   logic [`SERV_XLEN-1:0]   i_ibus_rdt;
   logic                    i_ibus_ack;
   logic [`SERV_XLEN-1:0]   o_dbus_adr;
   logic [`SERV_XLEN-1:0]   o_dbus_dat;
   logic [`SERV_XLEN/8-1:0] o_dbus_sel;
   logic                    o_dbus_we;
   logic                    o_dbus_cyc;
   logic                    i_dbus_ack;

   logic [31:0] prog [PROG_WORDS];
   logic [31:0] ref_regs [32];
   logic [31:0] fetch_log [$];
   store_t      exp_stores [$];
   store_t      got_stores [$];
   int          n_insn;
   int          err_count;
   int          test_fails;
   int          cycles;
   logic        ibus_busy;
   logic [1:0]  ibus_wait;
   logic [31:0] ibus_adr_q;
   logic        dbus_busy;
   int          dbus_wait;
   int          dbus_delay;
   store_t      dbus_req;
   logic        dbus_cyc_seen;

   serv_top serv_top_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   task automatic report_error(input string msg);
      err_count++;
      $display("[ERROR] %0d ns: %s", $time, msg);
   endtask

   // Instruction memory acks 1 to 4 cycles after the request shows up
   always @(negedge clk) begin
      if (i_reset || i_ibus_ack) begin
         i_ibus_ack <= 1'b0;
         ibus_busy  <= 1'b0;
      end else if (o_ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy  <= 1'b1;
            ibus_wait  <= 2'($urandom % 4);
            ibus_adr_q <= o_ibus_adr;
         end else if (ibus_wait == 2'd0) begin
            if (o_ibus_adr !== ibus_adr_q) begin
               report_error($sformatf("fetch address moved from %h to %h", ibus_adr_q,
                                      o_ibus_adr));
            end
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= prog[o_ibus_adr[9:2]];
            fetch_log.push_back(o_ibus_adr);
         end else begin
            ibus_wait <= ibus_wait - 2'd1;
         end
      end
   end

   // Data memory with a per-test ack delay
   always @(negedge clk) begin
      if (o_ibus_cyc && o_dbus_cyc) begin
         report_error("instruction fetch while a store is pending");
      end
      if (i_reset || i_dbus_ack) begin
         i_dbus_ack <= 1'b0;
         dbus_busy  <= 1'b0;
      end else if (o_dbus_cyc) begin
         dbus_cyc_seen = 1'b1;
         if (!dbus_busy) begin
            dbus_busy    <= 1'b1;
            dbus_wait    <= dbus_delay;
            dbus_req.adr <= o_dbus_adr;
            dbus_req.dat <= o_dbus_dat;
         end else begin
            if (o_dbus_adr !== dbus_req.adr || o_dbus_dat !== dbus_req.dat) begin
               report_error($sformatf("store changed while waiting: %h/%h now %h/%h",
                                      dbus_req.adr, dbus_req.dat, o_dbus_adr, o_dbus_dat));
            end
            if (dbus_wait == 0) begin
               if (o_dbus_sel !== 4'hf || o_dbus_we !== 1'b1) begin
                  report_error($sformatf("store with sel %b we %b", o_dbus_sel, o_dbus_we));
               end
               i_dbus_ack <= 1'b1;
               got_stores.push_back(dbus_req);
            end else begin
               dbus_wait <= dbus_wait - 1;
            end
         end
      end else if (dbus_busy) begin
         report_error("data bus request dropped before its ack");
         dbus_busy <= 1'b0;
      end
   end

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   // Integer rule for the supported funct3 codes
   function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
      case (f3)
         F3_ADD:  return sub ? a - b : a + b;
         F3_XOR:  return a ^ b;
         F3_OR:   return a | b;
         F3_AND:  return a & b;
         default: return 32'h0;
      endcase
   endfunction

   task automatic put_insn(input logic [31:0] word);
      prog[n_insn] = word;
      n_insn++;
   endtask

   task automatic write_ref(input logic [4:0] rd, input logic [31:0] v);
      if (rd != 5'd0) begin
         ref_regs[rd] = v;
      end
   endtask

   task automatic emit_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
      put_insn(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
      write_ref(rd, alu_rule(f3, 1'b0, ref_regs[rs1], sext12(imm)));
   endtask

   task automatic emit_reg(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
      put_insn(enc_r(sub ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP));
      write_ref(rd, alu_rule(f3, sub, ref_regs[rs1], ref_regs[rs2]));
   endtask

   task automatic emit_lui(input logic [4:0] rd, input logic [19:0] imm20);
      put_insn({imm20, rd, OPC_LUI});
      write_ref(rd, {imm20, 12'h000});
   endtask

   task automatic emit_sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] off);
      store_t s;
      put_insn(enc_s(off, rs2, rs1, F3_SW));
      s.adr = ref_regs[rs1] + sext12(off);
      s.dat = ref_regs[rs2];
      exp_stores.push_back(s);
   endtask

   // LUI then ADDI with the upper part rounded for the sign of the low 12 bits
   task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = (value + 32'h800) >> 12;
      emit_lui(rd, upper[19:0]);
      emit_imm(F3_ADD, rd, rd, value[11:0]);
   endtask

   task automatic start_test();
      int i;
      @(negedge clk);
      i_reset <= 1'b1;
      @(posedge clk);
      for (i = 0; i < PROG_WORDS; i++) begin
         prog[i] = NOP_WORD;
      end
      n_insn = 0;
      exp_stores.delete();
   endtask

   task automatic run_program(input int delay);
      int k;
      dbus_delay = delay;
      repeat (3) @(posedge clk);
      @(negedge clk);
      if (o_ibus_cyc || o_dbus_cyc) begin
         report_error("bus request active during reset");
      end
      fetch_log.delete();
      got_stores.delete();
      dbus_cyc_seen = 1'b0;
      i_reset <= 1'b0;
      // The fetch after the last slot means the whole program retired
      while (fetch_log.size() <= n_insn) begin
         @(posedge clk);
      end
      for (k = 0; k <= n_insn; k++) begin
         if (fetch_log[k] !== `SERV_RESET_PC + 32'(4 * k)) begin
            report_error($sformatf("fetch %0d at %h", k, fetch_log[k]));
         end
      end
      if (got_stores.size() != exp_stores.size()) begin
         report_error($sformatf("%0d stores seen, %0d expected", got_stores.size(),
                                exp_stores.size()));
      end else begin
         for (k = 0; k < exp_stores.size(); k++) begin
            if (got_stores[k] !== exp_stores[k]) begin
               report_error($sformatf("store %0d got %h/%h expected %h/%h", k,
                                      got_stores[k].adr, got_stores[k].dat,
                                      exp_stores[k].adr, exp_stores[k].dat));
            end
         end
      end
   endtask

   task automatic end_test(input string name, input int start);
      if (err_count == start) begin
         $display("%s: ok", name);
      end else begin
         test_fails++;
         $display("%s: FAILED with %0d errors", name, err_count - start);
      end
   endtask

   task automatic test_reset_fetch();
      int start;
      start = err_count;
      start_test();
      put_insn(NOP_WORD);
      put_insn(NOP_WORD);
      put_insn(NOP_WORD);
      run_program(0);
      if (dbus_cyc_seen) begin
         report_error("data bus request without a store");
      end
      end_test("reset_fetch", start);
   endtask

   task automatic test_const_store();
      int start;
      start = err_count;
      start_test();
      set_reg(5'd1, 32'h0000_1000);
      set_reg(5'd2, 32'h1234_5678);
      set_reg(5'd3, 32'hdead_beef);
      emit_imm(F3_ADD, 5'd4, 5'd0, 12'hff6);
      emit_imm(F3_ADD, 5'd5, 5'd2, 12'h800);
      emit_sw(5'd2, 5'd1, 12'h010);
      emit_sw(5'd3, 5'd1, 12'hffc);
      emit_sw(5'd4, 5'd1, 12'h7ff);
      emit_sw(5'd5, 5'd3, 12'h800);
      run_program(1);
      end_test("const_store", start);
   endtask

   task automatic test_add_sub();
      int          start;
      int          i;
      logic [31:0] a;
      logic [31:0] b;
      start = err_count;
      start_test();
      for (i = 0; i < 4; i++) begin
         a = $urandom;
         b = $urandom;
         // Carry through all 32 bits and then a borrow that wraps
         if (i == 0) begin
            a = 32'hffff_ffff;
            b = 32'h0000_0001;
         end else if (i == 1) begin
            a = 32'h0000_0000;
            b = 32'h0000_0001;
         end
         set_reg(5'd6, a);
         set_reg(5'd7, b);
         emit_reg(F3_ADD, 1'b0, 5'd8, 5'd6, 5'd7);
         emit_reg(F3_ADD, 1'b1, 5'd9, 5'd6, 5'd7);
         emit_sw(5'd8, 5'd0, 12'(16 * i));
         emit_sw(5'd9, 5'd0, 12'(16 * i + 4));
      end
      run_program(0);
      end_test("add_sub", start);
   endtask

   task automatic test_logic_ops();
      int          start;
      int          i;
      logic [11:0] imm;
      logic [11:0] base;
      start = err_count;
      start_test();
      for (i = 0; i < 3; i++) begin
         imm  = 12'($urandom);
         base = 12'(12'h200 + 32 * i);
         set_reg(5'd13, $urandom);
         set_reg(5'd14, $urandom);
         emit_reg(F3_XOR, 1'b0, 5'd15, 5'd13, 5'd14);
         emit_reg(F3_OR, 1'b0, 5'd16, 5'd13, 5'd14);
         emit_reg(F3_AND, 1'b0, 5'd17, 5'd13, 5'd14);
         emit_imm(F3_XOR, 5'd18, 5'd13, imm);
         emit_imm(F3_OR, 5'd19, 5'd13, imm);
         emit_imm(F3_AND, 5'd20, 5'd13, imm);
         emit_sw(5'd15, 5'd0, base);
         emit_sw(5'd16, 5'd0, base + 12'd4);
         emit_sw(5'd17, 5'd0, base + 12'd8);
         emit_sw(5'd18, 5'd0, base + 12'd12);
         emit_sw(5'd19, 5'd0, base + 12'd16);
         emit_sw(5'd20, 5'd0, base + 12'd20);
      end
      run_program(2);
      end_test("logic_ops", start);
   endtask

   task automatic test_x0_and_nop();
      int start;
      start = err_count;
      start_test();
      set_reg(5'd10, 32'h0bad_f00d);
      emit_imm(F3_ADD, 5'd0, 5'd10, 12'h123);
      emit_reg(F3_ADD, 1'b0, 5'd0, 5'd10, 5'd10);
      emit_imm(F3_OR, 5'd11, 5'd0, 12'h000);
      emit_sw(5'd0, 5'd0, 12'h300);
      emit_sw(5'd11, 5'd0, 12'h304);
      // LW, SLLI, MUL and SH leave x10 alone and touch no bus
      put_insn(enc_i(12'h000, 5'd10, F3_SW, 5'd10, OPC_LOAD));
      put_insn(enc_i(12'h003, 5'd10, 3'b001, 5'd10, OPC_OP_IMM));
      put_insn(enc_r(7'h01, 5'd10, 5'd10, F3_ADD, 5'd10, OPC_OP));
      put_insn(enc_s(12'h040, 5'd10, 5'd0, 3'b001));
      emit_sw(5'd10, 5'd0, 12'h308);
      run_program(3);
      end_test("x0_and_nop", start);
   endtask

   task automatic test_backpressure();
      int start;
      start = err_count;
      start_test();
      set_reg(5'd21, 32'h0000_4000);
      set_reg(5'd22, 32'hcafe_0123);
      emit_sw(5'd22, 5'd21, 12'h008);
      emit_sw(5'd21, 5'd22, 12'hffc);
      emit_imm(F3_XOR, 5'd23, 5'd22, 12'h0ff);
      emit_sw(5'd23, 5'd21, 12'h010);
      run_program(10);
      end_test("backpressure", start);
   endtask

   initial begin : watchdog
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
      end
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(32'hb7ddb21a));
      i_reset       = 1'b1;
      i_ibus_rdt    = '0;
      i_ibus_ack    = 1'b0;
      i_dbus_ack    = 1'b0;
      ibus_busy     = 1'b0;
      ibus_wait     = 2'd0;
      dbus_busy     = 1'b0;
      dbus_wait     = 0;
      dbus_delay    = 0;
      dbus_cyc_seen = 1'b0;
      err_count     = 0;
      test_fails    = 0;
      cycles        = 0;
      n_insn        = 0;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = 32'h0;
      end
      test_reset_fetch();
      test_const_store();
      test_add_sub();
      test_logic_ops();
      test_x0_and_nop();
      test_backpressure();
      $display("Summary: %0d tests, %0d failed, %0d errors", N_TESTS, test_fails, err_count);
      if (err_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
